//--- rtl/reg_defs_pkg.sv
`default_nettype none

package reg_defs_pkg;

  // general register file geometry
  localparam int data_w  = 32;
  localparam int gpr_aw  = 5;
  localparam int num_gpr = 32;

  // debug command FIFO
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // command word is {write, space, index, data}
  localparam int cmd_w       = 1 + 1 + gpr_aw + data_w;
  localparam int cmd_we_bit  = cmd_w - 1;
  localparam int cmd_sp_bit  = cmd_w - 2;
  localparam int cmd_idx_lsb = data_w;

  // space select values
  localparam logic dbg_space_gpr = 1'b0;
  localparam logic dbg_space_ctl = 1'b1;

endpackage

`default_nettype wire

//--- rtl/ctl_defs_pkg.sv
`default_nettype none

package ctl_defs_pkg;

  import reg_defs_pkg::*;

  localparam int ctl_aw = 3;

  // control register indices
  localparam logic [ctl_aw-1:0] cr_psr = 3'd0;  // privilege depth
  localparam logic [ctl_aw-1:0] cr_pid = 3'd1;
  localparam logic [ctl_aw-1:0] cr_isr = 3'd2;  // sticky interrupt status
  localparam logic [ctl_aw-1:0] cr_imr = 3'd3;  // enable + mask
  localparam logic [ctl_aw-1:0] cr_epc = 3'd4;
  localparam logic [ctl_aw-1:0] cr_efg = 3'd5;  // exception flags
  localparam logic [ctl_aw-1:0] cr_cdv = 3'd6;
  localparam logic [ctl_aw-1:0] cr_tlb = 3'd7;

  // cpu comes out of reset in kernel mode
  localparam logic [data_w-1:0] psr_reset = 32'd1;

  localparam int irq_w = 16;
  localparam int pid_w = 12;

  typedef struct packed {
    logic                      ie;
    logic [data_w-irq_w-2:0]   rsvd;
    logic [irq_w-1:0]          mask;
  } imr_fields_t;

  // register 3, seen as a plain word or as its fields
  typedef union packed {
    logic [data_w-1:0] raw;
    imr_fields_t       fields;
  } imr_u;

endpackage

`default_nettype wire

//--- rtl/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file import reg_defs_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic [gpr_aw-1:0] raddr0,
  input  logic [gpr_aw-1:0] raddr1,
  output logic [data_w-1:0] rdata0,
  output logic [data_w-1:0] rdata1,
  input  logic              wen0,
  input  logic [gpr_aw-1:0] waddr0,
  input  logic [data_w-1:0] wdata0,
  input  logic              wen1,
  input  logic [gpr_aw-1:0] waddr1,
  input  logic [data_w-1:0] wdata1,
  input  logic              dbg_we,
  input  logic              dbg_re,
  input  logic [gpr_aw-1:0] dbg_idx,
  input  logic [data_w-1:0] dbg_wdata,
  output logic [data_w-1:0] dbg_rdata,
  output logic              dbg_ready
);

  logic [data_w-1:0] regs [num_gpr];
  logic              wr1_ok;

  // port 0 (load data) beats port 1 on the same register
  assign wr1_ok = wen1 && !(wen0 && (waddr0 == waddr1));

  // debug only gets the write path when the pipeline leaves it idle
  assign dbg_ready = !wen0 && !wen1;

  always_ff @(posedge clk) begin
    if (wen0) begin
      regs[waddr0] <= wdata0;
    end
    if (wr1_ok) begin
      regs[waddr1] <= wdata1;
    end
    if (dbg_we && dbg_ready) begin
      regs[dbg_idx] <= dbg_wdata;
    end
  end

  // read ports hold their value under stall
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata0 <= '0;
      rdata1 <= '0;
    end else if (!stall) begin
      rdata0 <= (raddr0 == '0) ? '0 : regs[raddr0];
      rdata1 <= (raddr1 == '0) ? '0 : regs[raddr1];
    end
  end

  always_ff @(posedge clk) begin
    if (dbg_re && dbg_ready) begin
      dbg_rdata <= (dbg_idx == '0) ? '0 : regs[dbg_idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/ctl_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_reg_file import reg_defs_pkg::*, ctl_defs_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              clk_en,
  input  logic              stall,
  input  logic [ctl_aw-1:0] raddr0,
  output logic [data_w-1:0] rdata0,
  input  logic              wen0,
  input  logic [ctl_aw-1:0] waddr0,
  input  logic [data_w-1:0] wdata0,
  input  logic              exc_in_wb,
  input  logic              tlb_exc_in_wb,
  input  logic [data_w-1:0] tlb_addr,
  input  logic [data_w-1:0] epc,
  input  logic [data_w-1:0] efg,
  input  logic [irq_w-1:0]  interrupts,
  input  logic              interrupt_in_wb,
  input  logic              rfe_in_wb,
  input  logic              rfi_in_wb,
  output logic              kmode,
  output logic [data_w-1:0] cdv_out,
  output logic [pid_w-1:0]  pid,
  output logic [data_w-1:0] interrupt_state,
  input  logic              dbg_we,
  input  logic              dbg_re,
  input  logic [ctl_aw-1:0] dbg_idx,
  input  logic [data_w-1:0] dbg_wdata,
  output logic [data_w-1:0] dbg_rdata,
  output logic              dbg_ready
);

  logic [data_w-1:0] regs [2**ctl_aw];
  logic [data_w-1:0] irq_word;
  imr_u              imr;
  imr_u              imr_clr;
  imr_u              imr_set;
  logic              ev_ok;
  logic              pipe_wr;
  logic              dbg_wr;

  assign irq_word = {{(data_w - irq_w){1'b0}}, interrupts};
  assign ev_ok    = clk_en && !stall;
  assign pipe_wr  = wen0 && clk_en;

  // no debug access while the pipeline writes or an event is in writeback
  assign dbg_ready = clk_en && !wen0 && !exc_in_wb && !rfe_in_wb;
  assign dbg_wr    = dbg_we && dbg_ready;

  assign imr = regs[cr_imr];

  // register 3 with the global enable forced off / on
  always_comb begin
    imr_clr           = imr;
    imr_clr.fields.ie = 1'b0;
    imr_set           = imr;
    imr_set.fields.ie = 1'b1;
  end

  assign kmode           = (regs[cr_psr] != '0);
  assign cdv_out         = regs[cr_cdv];
  assign pid             = regs[cr_pid][pid_w-1:0];
  assign interrupt_state = imr.fields.ie ? (regs[cr_isr] & imr.raw) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**ctl_aw; i++) begin
        regs[i] <= (i == int'(cr_psr)) ? psr_reset : '0;
      end
      rdata0 <= '0;
    end else begin
      if (pipe_wr) begin
        regs[waddr0] <= wdata0;
      end else if (dbg_wr) begin
        regs[dbg_idx] <= dbg_wdata;
      end

      // read and events only advance on enabled, unstalled edges
      if (ev_ok) begin
        if (!exc_in_wb && !rfe_in_wb) begin
          rdata0 <= regs[raddr0];
        end else if (exc_in_wb) begin
          if (tlb_exc_in_wb) begin
            regs[cr_tlb] <= tlb_addr;
          end
          if (interrupt_in_wb) begin
            regs[cr_imr] <= imr_clr.raw;
          end
          regs[cr_epc] <= epc;
          regs[cr_efg] <= efg;
          regs[cr_psr] <= regs[cr_psr] + 1'b1;
        end else begin
          if (rfi_in_wb) begin
            regs[cr_imr] <= imr_set.raw;
          end
          regs[cr_psr] <= regs[cr_psr] - 1'b1;
        end
      end

      // interrupt lines are sticky, merged even into a write of register 2
      if (pipe_wr && (waddr0 == cr_isr)) begin
        regs[cr_isr] <= wdata0 | irq_word;
      end else if (dbg_wr && (dbg_idx == cr_isr)) begin
        regs[cr_isr] <= dbg_wdata | irq_word;
      end else begin
        regs[cr_isr] <= regs[cr_isr] | irq_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dbg_re && dbg_ready) begin
      dbg_rdata <= regs[dbg_idx];
    end
  end

endmodule

`default_nettype wire

//--- rtl/dbg_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_apb_port import reg_defs_pkg::*, ctl_defs_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [7:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              push,
  output logic [cmd_w-1:0]  push_cmd,
  input  logic              full,
  input  logic              rsp_valid,
  input  logic [data_w-1:0] rsp_data
);

  logic              access;
  logic              space;
  logic [gpr_aw-1:0] idx;
  logic              unmapped;
  logic              pushed;
  logic [data_w-1:0] cmd_data;

  assign access = psel && penable;

  // word addresses: bit 7 picks the space, bits 6..2 the index
  assign space = paddr[7];
  assign idx   = paddr[6:2];

  // control file only has 8 entries
  assign unmapped = (space == dbg_space_ctl) && (idx[gpr_aw-1:ctl_aw] != '0);

  // a read is pushed once, then waits for its response
  assign push     = access && !unmapped && !full && (pwrite || !pushed);
  assign cmd_data = pwrite ? pwdata : '0;
  assign push_cmd = {pwrite, space, idx, cmd_data};

  always_comb begin
    pready  = 1'b0;
    pslverr = 1'b0;
    prdata  = '0;
    if (access) begin
      if (unmapped) begin
        pready  = 1'b1;
        pslverr = 1'b1;
      end else if (pwrite) begin
        // posted write, done as soon as the FIFO takes it
        pready = !full;
      end else begin
        pready = pushed && rsp_valid;
        prdata = rsp_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pushed <= 1'b0;
    end else if (pready) begin
      pushed <= 1'b0;
    end else if (push && !pwrite) begin
      pushed <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/dbg_cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fifo import reg_defs_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [cmd_w-1:0] push_cmd,
  output logic             full,
  input  logic             pop,
  output logic [cmd_w-1:0] pop_cmd,
  output logic             empty
);

  logic [cmd_w-1:0]      mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count == fifo_cnt_w'(fifo_depth));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign pop_cmd = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dbg_cmd_exec.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_exec import reg_defs_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              empty,
  input  logic [cmd_w-1:0]  pop_cmd,
  output logic              pop,
  input  logic              gpr_ready,
  input  logic              ctl_ready,
  output logic              dbg_we_gpr,
  output logic              dbg_re_gpr,
  output logic              dbg_we_ctl,
  output logic              dbg_re_ctl,
  output logic [gpr_aw-1:0] dbg_idx,
  output logic [data_w-1:0] dbg_wdata,
  input  logic [data_w-1:0] gpr_rdata,
  input  logic [data_w-1:0] ctl_rdata,
  output logic              rsp_valid,
  output logic [data_w-1:0] rsp_data
);

  logic cmd_we;
  logic cmd_sp;
  logic to_ctl;
  logic tgt_ready;
  logic issue;
  logic rd_pend;
  logic rd_sp;

  // head command fields
  assign cmd_we    = pop_cmd[cmd_we_bit];
  assign cmd_sp    = pop_cmd[cmd_sp_bit];
  assign dbg_idx   = pop_cmd[cmd_idx_lsb +: gpr_aw];
  assign dbg_wdata = pop_cmd[data_w-1:0];

  assign to_ctl    = (cmd_sp == dbg_space_ctl);
  assign tgt_ready = to_ctl ? ctl_ready : gpr_ready;

  // executed and popped in the same cycle
  assign issue = !empty && tgt_ready;
  assign pop   = issue;

  assign dbg_we_gpr = issue && cmd_we && (cmd_sp == dbg_space_gpr);
  assign dbg_re_gpr = issue && !cmd_we && (cmd_sp == dbg_space_gpr);
  assign dbg_we_ctl = issue && cmd_we && to_ctl;
  assign dbg_re_ctl = issue && !cmd_we && to_ctl;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= issue && !cmd_we;
    end
  end

  // which file the outstanding read went to
  always_ff @(posedge clk) begin
    if (issue) begin
      rd_sp <= cmd_sp;
    end
  end

  assign rsp_valid = rd_pend;
  assign rsp_data  = (rd_sp == dbg_space_ctl) ? ctl_rdata : gpr_rdata;

endmodule

`default_nettype wire

//--- rtl/reg_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module reg_unit_top import reg_defs_pkg::*, ctl_defs_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic              clk_en,
  // general file pipeline side
  input  logic [gpr_aw-1:0] raddr0,
  input  logic [gpr_aw-1:0] raddr1,
  output logic [data_w-1:0] rdata0,
  output logic [data_w-1:0] rdata1,
  input  logic              wen0,
  input  logic [gpr_aw-1:0] waddr0,
  input  logic [data_w-1:0] wdata0,
  input  logic              wen1,
  input  logic [gpr_aw-1:0] waddr1,
  input  logic [data_w-1:0] wdata1,
  // control file pipeline side
  input  logic [ctl_aw-1:0] craddr,
  output logic [data_w-1:0] crdata,
  input  logic              cwen,
  input  logic [ctl_aw-1:0] cwaddr,
  input  logic [data_w-1:0] cwdata,
  input  logic              exc_in_wb,
  input  logic              tlb_exc_in_wb,
  input  logic [data_w-1:0] tlb_addr,
  input  logic [data_w-1:0] epc,
  input  logic [data_w-1:0] efg,
  input  logic [irq_w-1:0]  interrupts,
  input  logic              interrupt_in_wb,
  input  logic              rfe_in_wb,
  input  logic              rfi_in_wb,
  output logic              kmode,
  output logic [data_w-1:0] cdv_out,
  output logic [pid_w-1:0]  pid,
  output logic [data_w-1:0] interrupt_state,
  // debug host
  input  logic [7:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic              push;
  logic [cmd_w-1:0]  push_cmd;
  logic              full;
  logic              pop;
  logic [cmd_w-1:0]  pop_cmd;
  logic              empty;
  logic              gpr_ready;
  logic              ctl_ready;
  logic              dbg_we_gpr;
  logic              dbg_re_gpr;
  logic              dbg_we_ctl;
  logic              dbg_re_ctl;
  logic [gpr_aw-1:0] dbg_idx;
  logic [data_w-1:0] dbg_wdata;
  logic [data_w-1:0] gpr_rdata;
  logic [data_w-1:0] ctl_rdata;
  logic              rsp_valid;
  logic [data_w-1:0] rsp_data;

  dbg_apb_port i_apb (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .push      (push),
    .push_cmd  (push_cmd),
    .full      (full),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

  dbg_cmd_fifo i_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_cmd (push_cmd),
    .full     (full),
    .pop      (pop),
    .pop_cmd  (pop_cmd),
    .empty    (empty)
  );

  dbg_cmd_exec i_exec (
    .clk        (clk),
    .rst        (rst),
    .empty      (empty),
    .pop_cmd    (pop_cmd),
    .pop        (pop),
    .gpr_ready  (gpr_ready),
    .ctl_ready  (ctl_ready),
    .dbg_we_gpr (dbg_we_gpr),
    .dbg_re_gpr (dbg_re_gpr),
    .dbg_we_ctl (dbg_we_ctl),
    .dbg_re_ctl (dbg_re_ctl),
    .dbg_idx    (dbg_idx),
    .dbg_wdata  (dbg_wdata),
    .gpr_rdata  (gpr_rdata),
    .ctl_rdata  (ctl_rdata),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

  gpr_file i_gpr (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .raddr0    (raddr0),
    .raddr1    (raddr1),
    .rdata0    (rdata0),
    .rdata1    (rdata1),
    .wen0      (wen0),
    .waddr0    (waddr0),
    .wdata0    (wdata0),
    .wen1      (wen1),
    .waddr1    (waddr1),
    .wdata1    (wdata1),
    .dbg_we    (dbg_we_gpr),
    .dbg_re    (dbg_re_gpr),
    .dbg_idx   (dbg_idx),
    .dbg_wdata (dbg_wdata),
    .dbg_rdata (gpr_rdata),
    .dbg_ready (gpr_ready)
  );

  // control space uses only the low index bits
  ctl_reg_file i_ctl (
    .clk             (clk),
    .rst             (rst),
    .clk_en          (clk_en),
    .stall           (stall),
    .raddr0          (craddr),
    .rdata0          (crdata),
    .wen0            (cwen),
    .waddr0          (cwaddr),
    .wdata0          (cwdata),
    .exc_in_wb       (exc_in_wb),
    .tlb_exc_in_wb   (tlb_exc_in_wb),
    .tlb_addr        (tlb_addr),
    .epc             (epc),
    .efg             (efg),
    .interrupts      (interrupts),
    .interrupt_in_wb (interrupt_in_wb),
    .rfe_in_wb       (rfe_in_wb),
    .rfi_in_wb       (rfi_in_wb),
    .kmode           (kmode),
    .cdv_out         (cdv_out),
    .pid             (pid),
    .interrupt_state (interrupt_state),
    .dbg_we          (dbg_we_ctl),
    .dbg_re          (dbg_re_ctl),
    .dbg_idx         (dbg_idx[ctl_aw-1:0]),
    .dbg_wdata       (dbg_wdata),
    .dbg_rdata       (ctl_rdata),
    .dbg_ready       (ctl_ready)
  );

endmodule

`default_nettype wire

//--- verif/reg_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module reg_unit_asserts (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic push,
  input logic full,
  input logic pop,
  input logic empty
);

  int fail_count = 0;

  // completion only inside an access phase
  pready_in_access: assert property (@(posedge clk) disable iff (rst)
    pready |-> (psel && penable))
    else begin
      fail_count++;
      $error("pready high outside an APB access phase");
    end

  no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else begin
      fail_count++;
      $error("command pushed while the FIFO is full");
    end

  no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else begin
      fail_count++;
      $error("command popped while the FIFO is empty");
    end

endmodule

bind dbg_apb_port reg_unit_asserts i_apb_asserts (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .push    (push),
  .full    (full),
  .pop     (1'b0),
  .empty   (1'b0)
);

bind dbg_cmd_fifo reg_unit_asserts i_fifo_asserts (
  .clk     (clk),
  .rst     (rst),
  .psel    (1'b0),
  .penable (1'b0),
  .pready  (1'b0),
  .push    (push),
  .full    (full),
  .pop     (pop),
  .empty   (empty)
);

`default_nettype wire

//--- verif/reg_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module reg_unit_tb import reg_defs_pkg::*, ctl_defs_pkg::*; ();

  // reset, gpr init, random phase, busy phase and control phases
  localparam int sched_cycles   = 10 + 32 + 200 + 40 + 80;
  localparam int apb_xfers      = 35;
  localparam int timeout_cycles = sched_cycles + 50 * apb_xfers + 200;

  logic clk;
  logic rst;
  logic stall;
  logic clk_en;
  logic [gpr_aw-1:0] raddr0;
  logic [gpr_aw-1:0] raddr1;
  logic [data_w-1:0] rdata0;
  logic [data_w-1:0] rdata1;
  logic wen0;
  logic [gpr_aw-1:0] waddr0;
  logic [data_w-1:0] wdata0;
  logic wen1;
  logic [gpr_aw-1:0] waddr1;
  logic [data_w-1:0] wdata1;
  logic [ctl_aw-1:0] craddr;
  logic [data_w-1:0] crdata;
  logic cwen;
  logic [ctl_aw-1:0] cwaddr;
  logic [data_w-1:0] cwdata;
  logic exc_in_wb;
  logic tlb_exc_in_wb;
  logic [data_w-1:0] tlb_addr;
  logic [data_w-1:0] epc;
  logic [data_w-1:0] efg;
  logic [irq_w-1:0] interrupts;
  logic interrupt_in_wb;
  logic rfe_in_wb;
  logic rfi_in_wb;
  logic kmode;
  logic [data_w-1:0] cdv_out;
  logic [pid_w-1:0] pid;
  logic [data_w-1:0] interrupt_state;
  logic [7:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [data_w-1:0] pwdata;
  logic [data_w-1:0] prdata;
  logic pready;
  logic pslverr;

  // reference state
  logic [data_w-1:0] gpr_m [num_gpr];
  logic [data_w-1:0] ctl_m [8];
  logic [data_w-1:0] exp_rd0;
  logic [data_w-1:0] exp_rd1;
  logic [data_w-1:0] exp_cr;
  logic chk_rd;
  logic chk_cr;
  int nerr;
  int nchk;
  int cycles;

  reg_unit_top i_dut (.*);

  always #2 clk = ~clk;

  task automatic check_word(input string name, input logic [data_w-1:0] exp,
                            input logic [data_w-1:0] act);
    nchk++;
    if (act !== exp) begin
      nerr++;
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    nchk++;
    if (act !== exp) begin
      nerr++;
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  // one clock of control events, as seen at the coming edge
  function automatic void ref_ctl_step();
    imr_u u;
    if (clk_en && cwen) begin
      ctl_m[cwaddr] = cwdata;
    end
    if (clk_en && !stall) begin
      u.raw = ctl_m[cr_imr];
      if (exc_in_wb) begin
        if (tlb_exc_in_wb) begin
          ctl_m[cr_tlb] = tlb_addr;
        end
        if (interrupt_in_wb) begin
          u.fields.ie = 1'b0;
        end
        ctl_m[cr_imr] = u.raw;
        ctl_m[cr_epc] = epc;
        ctl_m[cr_efg] = efg;
        ctl_m[cr_psr] = ctl_m[cr_psr] + 32'd1;
      end else if (rfe_in_wb) begin
        if (rfi_in_wb) begin
          u.fields.ie = 1'b1;
        end
        ctl_m[cr_imr] = u.raw;
        ctl_m[cr_psr] = ctl_m[cr_psr] - 32'd1;
      end
    end
    ctl_m[cr_isr] = ctl_m[cr_isr] | {{(data_w - irq_w){1'b0}}, interrupts};
  endfunction

  function automatic logic [data_w-1:0] exp_istate();
    imr_u u;
    u.raw = ctl_m[cr_imr];
    return u.fields.ie ? (ctl_m[cr_isr] & u.raw) : '0;
  endfunction

  // registered read data, checked after the edge that loads it
  always begin
    @(posedge clk);
    #1;
    if (chk_rd) begin
      check_word("rdata0", exp_rd0, rdata0);
      check_word("rdata1", exp_rd1, rdata1);
    end
    if (chk_cr) begin
      check_word("crdata", exp_cr, crdata);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // entered and left at a falling edge
  task automatic apb_xfer(input logic wr, input logic sp, input logic [gpr_aw-1:0] idx,
                          input logic [data_w-1:0] wdata, output logic [data_w-1:0] rdata,
                          output logic err);
    paddr   = {sp, idx, 2'b00};
    pwrite  = wr;
    pwdata  = wr ? wdata : '0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic sp, input logic [gpr_aw-1:0] idx,
                           input logic [data_w-1:0] d, input logic exp_err);
    logic [data_w-1:0] rd;
    logic er;
    apb_xfer(1'b1, sp, idx, d, rd, er);
    check_bit("pslverr", exp_err, er);
  endtask

  task automatic apb_read_check(input logic sp, input logic [gpr_aw-1:0] idx,
                                input logic [data_w-1:0] exp, input logic exp_err);
    logic [data_w-1:0] rd;
    logic er;
    apb_xfer(1'b0, sp, idx, '0, rd, er);
    check_bit("pslverr", exp_err, er);
    check_word("prdata", exp, rd);
  endtask

  task automatic ctl_read_check(input logic [ctl_aw-1:0] idx);
    craddr = idx;
    exp_cr = ctl_m[idx];
    chk_cr = 1'b1;
    @(negedge clk);
    chk_cr = 1'b0;
  endtask

  // caller sets the event inputs, this applies them for one edge
  task automatic ctl_cycle();
    epc      = $urandom;
    efg      = $urandom;
    tlb_addr = $urandom;
    ref_ctl_step();
    @(negedge clk);
    exc_in_wb       = 1'b0;
    tlb_exc_in_wb   = 1'b0;
    interrupt_in_wb = 1'b0;
    rfe_in_wb       = 1'b0;
    rfi_in_wb       = 1'b0;
    cwen            = 1'b0;
    interrupts      = '0;
    check_bit("kmode", ctl_m[cr_psr] != '0, kmode);
    check_word("interrupt_state", exp_istate(), interrupt_state);
  endtask

  initial begin
    logic [31:0] r;
    logic [data_w-1:0] d;
    logic [data_w-1:0] dbg_vals [8];
    int afail;
    void'($urandom(61));
    clk = 1'b0;
    rst = 1'b1;
    {stall, wen0, wen1, cwen, exc_in_wb, tlb_exc_in_wb} = '0;
    {interrupt_in_wb, rfe_in_wb, rfi_in_wb, psel, penable, pwrite} = '0;
    clk_en = 1'b1;
    {raddr0, raddr1, waddr0, waddr1, craddr, cwaddr, paddr} = '0;
    {wdata0, wdata1, cwdata, tlb_addr, epc, efg, pwdata} = '0;
    interrupts = '0;
    {exp_rd0, exp_rd1, exp_cr, chk_rd, chk_cr} = '0;
    nerr = 0;
    nchk = 0;
    cycles = 0;
    foreach (ctl_m[i]) ctl_m[i] = '0;
    ctl_m[cr_psr] = 32'd1;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // general registers have no reset, fill them first
    for (int i = 0; i < num_gpr; i++) begin
      wen0 = 1'b1;
      waddr0 = 5'(i);
      wdata0 = $urandom;
      gpr_m[i] = wdata0;
      @(negedge clk);
    end
    wen0 = 1'b0;

    // random pipeline traffic with collisions and stalls
    for (int i = 0; i < 200; i++) begin
      r = $urandom;
      stall  = (r[1:0] == 2'b00);
      raddr0 = r[6:2];
      raddr1 = r[11:7];
      wen0   = r[12];
      wen1   = r[13];
      waddr0 = r[18:14];
      waddr1 = r[20] ? r[18:14] : r[25:21];
      wdata0 = $urandom;
      wdata1 = $urandom;
      if (!stall) begin
        exp_rd0 = (raddr0 == '0) ? '0 : gpr_m[raddr0];
        exp_rd1 = (raddr1 == '0) ? '0 : gpr_m[raddr1];
      end
      chk_rd = 1'b1;
      // port 0 is applied last so it wins a collision
      if (wen1) begin
        gpr_m[waddr1] = wdata1;
      end
      if (wen0) begin
        gpr_m[waddr0] = wdata0;
      end
      @(negedge clk);
    end
    {chk_rd, stall, wen0, wen1, raddr0, raddr1} = '0;

    // posted APB writes into both spaces, then read back
    for (int i = 8; i < 12; i++) begin
      d = $urandom;
      gpr_m[i] = d;
      apb_write(dbg_space_gpr, 5'(i), d, 1'b0);
    end
    ctl_m[cr_pid] = $urandom;
    apb_write(dbg_space_ctl, 5'(cr_pid), ctl_m[cr_pid], 1'b0);
    ctl_m[cr_imr] = 32'h8000_00ff;
    apb_write(dbg_space_ctl, 5'(cr_imr), ctl_m[cr_imr], 1'b0);
    ctl_m[cr_cdv] = $urandom;
    apb_write(dbg_space_ctl, 5'(cr_cdv), ctl_m[cr_cdv], 1'b0);
    ctl_m[cr_tlb] = $urandom;
    apb_write(dbg_space_ctl, 5'(cr_tlb), ctl_m[cr_tlb], 1'b0);
    apb_write(dbg_space_ctl, 5'd9, 32'hdead_beef, 1'b1);
    apb_read_check(dbg_space_ctl, 5'd12, '0, 1'b1);
    apb_read_check(dbg_space_gpr, 5'd0, '0, 1'b0);
    for (int i = 8; i < 12; i++) begin
      apb_read_check(dbg_space_gpr, 5'(i), gpr_m[i], 1'b0);
    end
    apb_read_check(dbg_space_ctl, 5'(cr_pid), ctl_m[cr_pid], 1'b0);
    apb_read_check(dbg_space_ctl, 5'(cr_imr), ctl_m[cr_imr], 1'b0);
    apb_read_check(dbg_space_ctl, 5'(cr_cdv), ctl_m[cr_cdv], 1'b0);
    apb_read_check(dbg_space_ctl, 5'(cr_tlb), ctl_m[cr_tlb], 1'b0);

    // debug writes queue up behind a busy pipeline that also writes their targets
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          wen0 = 1'b1;
          wen1 = 1'b1;
          waddr0 = 5'(20 + i % 5);
          waddr1 = 5'(3 + i % 5);
          wdata0 = $urandom;
          wdata1 = $urandom;
          gpr_m[waddr0] = wdata0;
          gpr_m[waddr1] = wdata1;
          @(negedge clk);
        end
        wen0 = 1'b0;
        wen1 = 1'b0;
      end
      begin
        for (int i = 3; i < 8; i++) begin
          dbg_vals[i] = $urandom;
          apb_write(dbg_space_gpr, 5'(i), dbg_vals[i], 1'b0);
        end
      end
    join
    // queued debug writes land after the last pipeline write
    for (int i = 3; i < 8; i++) begin
      gpr_m[i] = dbg_vals[i];
    end
    repeat (8) @(negedge clk);
    wen0 = 1'b1;
    waddr0 = 5'd7;
    wdata0 = $urandom;
    gpr_m[7] = wdata0;
    @(negedge clk);
    wen0 = 1'b0;
    for (int i = 3; i < 8; i++) begin
      apb_read_check(dbg_space_gpr, 5'(i), gpr_m[i], 1'b0);
    end
    apb_read_check(dbg_space_gpr, 5'd20, gpr_m[20], 1'b0);
    apb_read_check(dbg_space_gpr, 5'd24, gpr_m[24], 1'b0);

    // nested exceptions and returns
    exc_in_wb = 1'b1;
    tlb_exc_in_wb = 1'b1;
    interrupt_in_wb = 1'b1;
    ctl_cycle();
    exc_in_wb = 1'b1;
    ctl_cycle();
    for (int i = 0; i < 8; i++) begin
      ctl_read_check(3'(i));
    end
    rfe_in_wb = 1'b1;
    ctl_cycle();
    rfe_in_wb = 1'b1;
    rfi_in_wb = 1'b1;
    ctl_cycle();
    rfe_in_wb = 1'b1;
    ctl_cycle();
    ctl_read_check(cr_psr);
    ctl_read_check(cr_imr);
    apb_read_check(dbg_space_ctl, 5'(cr_psr), ctl_m[cr_psr], 1'b0);
    apb_read_check(dbg_space_ctl, 5'(cr_epc), ctl_m[cr_epc], 1'b0);

    // one-cycle interrupt pulses stick, gated by the enable bit
    interrupts = 16'h0a05;
    ctl_cycle();
    ctl_read_check(cr_isr);
    exc_in_wb = 1'b1;
    interrupt_in_wb = 1'b1;
    ctl_cycle();
    rfe_in_wb = 1'b1;
    rfi_in_wb = 1'b1;
    ctl_cycle();
    ctl_read_check(cr_imr);

    // clock enable low freezes everything but interrupt latching
    clk_en = 1'b0;
    exc_in_wb = 1'b1;
    interrupts = 16'h1000;
    cwen = 1'b1;
    cwaddr = cr_cdv;
    cwdata = 32'h1234_5678;
    ctl_cycle();
    rfe_in_wb = 1'b1;
    ctl_cycle();
    clk_en = 1'b1;
    for (int i = 0; i < 8; i++) begin
      ctl_read_check(3'(i));
    end
    check_word("cdv_out", ctl_m[cr_cdv], cdv_out);
    check_word("pid", data_w'(ctl_m[cr_pid][pid_w-1:0]), data_w'(pid));

    repeat (4) @(negedge clk);
    afail = i_dut.i_apb.i_apb_asserts.fail_count + i_dut.i_fifo.i_fifo_asserts.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", nchk, nerr, afail);
    if (nerr == 0 && afail == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
rtl/reg_defs_pkg.sv
rtl/ctl_defs_pkg.sv
rtl/gpr_file.sv
rtl/ctl_reg_file.sv
rtl/dbg_apb_port.sv
rtl/dbg_cmd_fifo.sv
rtl/dbg_cmd_exec.sv
rtl/reg_unit_top.sv
verif/reg_unit_asserts.sv
verif/reg_unit_tb.sv

//--- Makefile
TOP = reg_unit_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
